/* x86_alu.f */
+incdir+hw
hw/mmx_pkg.sv
hw/flag_pkg.sv
hw/scalar_unit.sv
hw/shift_unit.sv
hw/mmx_lane_feed.sv
hw/mmx_lane.sv
hw/mmx_lane_merge.sv
hw/alu_top.sv
verif/alu_assertions.sv
verif/alu_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= alu_tb
FILELIST   ?= x86_alu.f
OBJ_DIR    ?= obj_dir
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: run build lint clean

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^all tests passed$$"

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verif/alu_tb.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_tb;

    localparam int WAIT_LIMIT = 8;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic [4:0]             aluk;
    logic [`ALU_DATA_W-1:0] op1;
    logic [`ALU_DATA_W-1:0] op2;
    logic [1:0]             size;
    logic                   and_mask16;
    logic                   of_in;
    logic                   out_valid;
    logic [`ALU_DATA_W-1:0] alu_out;
    logic                   cf_out, pf_out, af_out, zf_out, sf_out, of_out;
    logic                   cc_inval;

    int                     errors;
    int                     checks;
    logic [31:0]            lcg_state;

    // expected response of the current operation
    logic [`ALU_DATA_W-1:0] exp_res;
    logic                   exp_cf, exp_pf, exp_af, exp_zf, exp_sf, exp_of, exp_cc;

    alu_top u_alu_top (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .aluk(aluk),
        .op1(op1), .op2(op2), .size(size), .and_mask16(and_mask16), .of_in(of_in),
        .out_valid(out_valid), .alu_out(alu_out), .cf_out(cf_out), .pf_out(pf_out),
        .af_out(af_out), .zf_out(zf_out), .sf_out(sf_out), .of_out(of_out),
        .cc_inval(cc_inval)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // stimulus source and reference model
    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    function automatic logic sign_bit(input logic [63:0] v, input logic [1:0] sz);
        case (sz)
            2'd0: return v[7];
            2'd1: return v[15];
            2'd2: return v[31];
            default: return v[63];
        endcase
    endfunction

    // signed word clamped into a byte
    function automatic logic [7:0] clamp_byte(input logic [15:0] w);
        int v;
        v = {{16{w[15]}}, w};
        if (v > 127)
            return 8'h7f;
        else if (v < -128)
            return 8'h80;
        else
            return w[7:0];
    endfunction

    task automatic model_op(input logic [4:0] k, input logic [63:0] a, input logic [63:0] b,
                            input logic [1:0] sz, input logic msk, input logic ofi);
        logic [32:0] s33;
        logic [4:0]  nib;
        logic [63:0] tmp;
        logic [31:0] lo;
        logic [31:0] sar_lo;
        logic [4:0]  cnt;
        logic        over;
        logic [1:0]  osz;
        exp_res = '0;
        exp_cf  = 1'b0;
        exp_of  = 1'b0;
        exp_af  = 1'b0;
        exp_cc  = 1'b0;
        lo      = a[31:0];
        cnt     = b[4:0];
        over    = |b[7:5];
        case (k)
            `ALUK_AND:  exp_res = a & (msk ? 64'h0000_0000_0000_ffff : b);
            `ALUK_OR:   exp_res = a | b;
            `ALUK_NOT:  exp_res = ~a;
            `ALUK_MOVA: exp_res = a;
            `ALUK_MOVB: exp_res = b;
            `ALUK_ADD: begin
                s33     = {1'b0, a[31:0]} + {1'b0, b[31:0]};
                nib     = {1'b0, a[3:0]} + {1'b0, b[3:0]};
                exp_res = {32'h0, s33[31:0]};
                exp_cf  = s33[32];
                exp_af  = nib[4];
                // qword size overflows at bit 31 like dword
                osz     = (sz == 2'd3) ? 2'd2 : sz;
                exp_of  = (sign_bit(a, osz) == sign_bit(b, osz)) &&
                          (sign_bit(exp_res, osz) != sign_bit(a, osz));
            end
            `ALUK_PADDW: begin
                for (int i = 0; i < 4; i++)
                    exp_res[16*i +: 16] = a[16*i +: 16] + b[16*i +: 16];
            end
            `ALUK_PADDD: exp_res = {a[63:32] + b[63:32], a[31:0] + b[31:0]};
            `ALUK_PACKSSWB: begin
                for (int i = 0; i < 4; i++) begin
                    exp_res[8*i +: 8]    = clamp_byte(a[16*i +: 16]);
                    exp_res[32+8*i +: 8] = clamp_byte(b[16*i +: 16]);
                end
            end
            `ALUK_PUNPCKHBW: begin
                for (int j = 0; j < 4; j++) begin
                    exp_res[16*j +: 8]   = a[32+8*j +: 8];
                    exp_res[16*j+8 +: 8] = b[32+8*j +: 8];
                end
            end
            `ALUK_SAL: begin
                if (over) begin
                    exp_cf = lo[31];
                end else begin
                    tmp     = {32'h0, lo} << cnt;
                    exp_res = {32'h0, tmp[31:0]};
                    exp_cf  = tmp[32];
                end
                exp_of = (cnt == 5'd1) ? (exp_res[31] ^ exp_cf) : ofi;
                exp_cc = (cnt == 5'd0);
            end
            `ALUK_SAR: begin
                if (over) begin
                    exp_res = {32'h0, {32{lo[31]}}};
                    exp_cf  = lo[31];
                end else begin
                    // bit 31 of the shifted pair is the last bit that fell off
                    tmp     = {lo, 32'h0} >> cnt;
                    sar_lo  = $signed(lo) >>> cnt;
                    exp_res = {32'h0, sar_lo};
                    exp_cf  = tmp[31];
                end
                exp_of = (cnt == 5'd1) ? 1'b0 : ofi;
                exp_cc = (cnt == 5'd0);
            end
            default: ;
        endcase
        exp_zf = (exp_res == 64'h0);
        exp_sf = sign_bit(exp_res, sz);
        exp_pf = ~^exp_res[7:0];
    endtask

    ////////////////////////////////////////////////////////////
    // checking and driving
    task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic run_op(input logic [4:0] k, input logic [63:0] a, input logic [63:0] b,
                          input logic [1:0] sz, input logic msk, input logic ofi);
        int wait_cnt;
        model_op(k, a, b, sz, msk, ofi);
        @(negedge clk);
        aluk       = k;
        op1        = a;
        op2        = b;
        size       = sz;
        and_mask16 = msk;
        of_in      = ofi;
        in_valid   = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        wait_cnt = 0;
        while (!out_valid && wait_cnt < WAIT_LIMIT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!out_valid) begin
            $display("timeout: no out_valid for aluk %0d", k);
            $display("tests failed");
            $finish;
        end else begin
            if (wait_cnt != 0) begin
                errors++;
                $display("result for aluk %0d came %0d cycles late", k, wait_cnt);
            end
            check_word("alu_out", alu_out, exp_res);
            check_bit("cf_out", cf_out, exp_cf);
            check_bit("pf_out", pf_out, exp_pf);
            check_bit("af_out", af_out, exp_af);
            check_bit("zf_out", zf_out, exp_zf);
            check_bit("sf_out", sf_out, exp_sf);
            check_bit("of_out", of_out, exp_of);
            check_bit("cc_inval", cc_inval, exp_cc);
            // single pulse and the result is held afterwards
            @(negedge clk);
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("cc_inval", cc_inval, 1'b0);
            check_word("alu_out", alu_out, exp_res);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    task automatic test_reset();
        check_bit("out_valid", out_valid, 1'b0);
        check_word("alu_out", alu_out, 64'h0);
        check_bit("cf_out", cf_out, 1'b0);
        check_bit("pf_out", pf_out, 1'b0);
        check_bit("af_out", af_out, 1'b0);
        check_bit("zf_out", zf_out, 1'b0);
        check_bit("sf_out", sf_out, 1'b0);
        check_bit("of_out", of_out, 1'b0);
        check_bit("cc_inval", cc_inval, 1'b0);
        run_op(`ALUK_MOVA, rand64(), rand64(), 2'd3, 1'b0, 1'b0);
    endtask

    task automatic test_logic();
        logic [63:0] a;
        logic [63:0] b;
        logic [31:0] r;
        for (int n = 0; n < 4; n++) begin
            a = rand64();
            b = rand64();
            r = lcg_next();
            run_op(`ALUK_AND, a, b, n[1:0], 1'b0, r[0]);
            run_op(`ALUK_AND, a, b, n[1:0], 1'b1, r[1]);
            run_op(`ALUK_OR, a, b, n[1:0], 1'b0, r[2]);
            run_op(`ALUK_NOT, a, b, n[1:0], 1'b0, r[3]);
            run_op(`ALUK_MOVA, a, b, n[1:0], 1'b0, r[4]);
            run_op(`ALUK_MOVB, a, b, n[1:0], 1'b0, r[5]);
        end
        run_op(`ALUK_AND, rand64(), 64'h0, 2'd2, 1'b0, 1'b0);
    endtask

    task automatic test_add();
        logic [31:0] r;
        run_op(`ALUK_ADD, 64'h7f, 64'h1, 2'd0, 1'b0, 1'b0);
        run_op(`ALUK_ADD, 64'h7fff, 64'h1, 2'd1, 1'b0, 1'b0);
        run_op(`ALUK_ADD, 64'hffff_ffff, 64'h1, 2'd2, 1'b0, 1'b0);
        run_op(`ALUK_ADD, 64'h7fff_ffff, 64'h1, 2'd2, 1'b0, 1'b0);
        run_op(`ALUK_ADD, 64'h0f, 64'h01, 2'd0, 1'b0, 1'b0);
        run_op(`ALUK_ADD, 64'hffff_ffff_0000_0080, 64'h0000_0001_0000_0080, 2'd0, 1'b0, 1'b0);
        for (int n = 0; n < 8; n++) begin
            r = lcg_next();
            run_op(`ALUK_ADD, rand64(), rand64(), r[1:0], 1'b0, r[2]);
        end
    endtask

    task automatic test_shift();
        logic [4:0]  k;
        logic [63:0] a;
        logic [63:0] b;
        logic [31:0] r;
        for (int s = 0; s < 2; s++) begin
            k = (s == 0) ? `ALUK_SAL : `ALUK_SAR;
            for (int n = 0; n < 3; n++) begin
                a = (n == 0) ? 64'h1234_5678_8000_0001 : rand64();
                b = rand64();
                r = lcg_next();
                run_op(k, a, {b[63:8], 8'h00}, 2'd2, 1'b0, r[0]);
                run_op(k, a, {b[63:8], 8'h01}, 2'd2, 1'b0, r[1]);
                run_op(k, a, {b[63:8], 3'b000, r[12:8]}, r[14:13], 1'b0, r[2]);
                run_op(k, a, {b[63:8], 8'h20}, 2'd2, 1'b0, r[3]);
                run_op(k, a, {b[63:8], 8'h45}, 2'd2, 1'b0, r[4]);
                run_op(k, a, {b[63:8], 8'he1}, 2'd2, 1'b0, r[5]);
            end
        end
    endtask

    task automatic test_mmx();
        run_op(`ALUK_PADDW, 64'h0000_ffff_0000_ffff, 64'h0000_0001_0000_0001, 2'd3, 1'b0, 1'b0);
        run_op(`ALUK_PADDD, 64'h0000_ffff_0000_ffff, 64'h0000_0001_0000_0001, 2'd3, 1'b0, 1'b0);
        run_op(`ALUK_PADDW, 64'hffff_0000_0000_0000, 64'h0001_0000_0000_0001, 2'd3, 1'b0, 1'b0);
        run_op(`ALUK_PADDD, 64'hffff_ffff_ffff_ffff, 64'h0000_0000_0000_0001, 2'd3, 1'b0, 1'b0);
        for (int n = 0; n < 4; n++) begin
            run_op(`ALUK_PADDW, rand64(), rand64(), 2'd3, 1'b0, 1'b0);
            run_op(`ALUK_PADDD, rand64(), rand64(), 2'd2, 1'b0, 1'b0);
        end
        run_op(`ALUK_PACKSSWB, 64'h0042_8000_7fff_ff80, 64'h007f_0080_ff7f_fffe,
               2'd3, 1'b0, 1'b0);
        for (int n = 0; n < 4; n++) begin
            run_op(`ALUK_PACKSSWB, rand64(), rand64(), 2'd3, 1'b0, 1'b0);
            run_op(`ALUK_PUNPCKHBW, rand64(), rand64(), 2'd3, 1'b0, 1'b0);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        aluk       = '0;
        op1        = '0;
        op2        = '0;
        size       = '0;
        and_mask16 = 1'b0;
        of_in      = 1'b0;
        errors     = 0;
        checks     = 0;
        lcg_state  = 32'h3f42;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_logic();
        test_add();
        test_shift();
        test_mmx();
        // failed assertions of the bound checker count as errors too
        errors = errors + u_alu_top.u_alu_assertions.fail_count;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* verif/alu_assertions.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   in_valid,
    input logic                   out_valid,
    input logic [`ALU_DATA_W-1:0] alu_out,
    input logic                   zf_out,
    input logic                   cc_inval
);

    // assertion failures so far
    int fail_count = 0;

    // one-cycle output stage
    a_valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (out_valid == $past(in_valid)))
        else begin
            $error("out_valid does not follow in_valid by one cycle");
            fail_count++;
        end

    a_zf_result: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (zf_out == (alu_out == '0)))
        else begin
            $error("zf_out disagrees with alu_out");
            fail_count++;
        end

    a_cc_inval_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> !cc_inval)
        else begin
            $error("cc_inval high without a valid result");
            fail_count++;
        end

endmodule

bind alu_top alu_assertions u_alu_assertions (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .out_valid(out_valid),
    .alu_out(alu_out), .zf_out(zf_out), .cc_inval(cc_inval)
);

/* hw/alu_top.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [4:0]             aluk,
    input  logic [`ALU_DATA_W-1:0] op1,
    input  logic [`ALU_DATA_W-1:0] op2,
    input  logic [1:0]             size,
    input  logic                   and_mask16,
    input  logic                   of_in,
    output logic                   out_valid,
    output logic [`ALU_DATA_W-1:0] alu_out,
    output logic                   cf_out,
    output logic                   pf_out,
    output logic                   af_out,
    output logic                   zf_out,
    output logic                   sf_out,
    output logic                   of_out,
    output logic                   cc_inval
);
    import flag_pkg::*;

    logic [`ALU_DATA_W-1:0] and_res, or_res, not_res, add_res;
    logic                   add_cf, add_of, add_af;
    logic [`ALU_DATA_W-1:0] sal_res, sar_res, mmx_res;
    logic                   sal_cf, sar_cf, sal_of, sar_of, count_zero;

    logic [`MMX_LANES-1:0][`MMX_LANE_W-1:0] lane_a, lane_b, lane_sum, lane_packed;
    logic [`MMX_LANES-1:0]                  carry_link, lane_cin, lane_cout;

    logic [`ALU_DATA_W-1:0] res_c;
    logic                   cf_c, of_c, af_c, zf_c, sf_c, pf_c, cc_inval_c;

    scalar_unit u_scalar_unit (
        .aluk(aluk), .op1(op1), .op2(op2), .size(size), .and_mask16(and_mask16),
        .and_res(and_res), .or_res(or_res), .not_res(not_res), .add_res(add_res),
        .add_cf(add_cf), .add_of(add_of), .add_af(add_af)
    );

    shift_unit u_shift_unit (
        .op1(op1), .op2(op2), .of_in(of_in), .sal_res(sal_res), .sar_res(sar_res),
        .sal_cf(sal_cf), .sar_cf(sar_cf), .sal_of(sal_of), .sar_of(sar_of),
        .count_zero(count_zero)
    );

    ////////////////////////////////////////////////////////////
    // simd lanes
    mmx_lane_feed u_mmx_lane_feed (
        .aluk(aluk), .op1(op1), .op2(op2),
        .lane_a(lane_a), .lane_b(lane_b), .carry_link(carry_link)
    );

    for (genvar i = 0; i < `MMX_LANES; i++) begin : g_lane
        // ring order, lane 0 looks at the top lane but its link stays low
        assign lane_cin[i] = carry_link[i] & lane_cout[(i + `MMX_LANES - 1) % `MMX_LANES];

        mmx_lane u_mmx_lane (
            .a(lane_a[i]), .b(lane_b[i]), .carry_in(lane_cin[i]),
            .sum(lane_sum[i]), .carry_out(lane_cout[i]), .packed_bytes(lane_packed[i])
        );
    end

    mmx_lane_merge u_mmx_lane_merge (
        .aluk(aluk), .op1(op1), .op2(op2),
        .lane_sum(lane_sum), .lane_packed(lane_packed), .mmx_res(mmx_res)
    );

    ////////////////////////////////////////////////////////////
    // result and flag select, unused codes give zero
    always_comb begin
        res_c = '0;
        cf_c  = 1'b0;
        of_c  = 1'b0;
        af_c  = 1'b0;
        case (aluk)
            `ALUK_AND:  res_c = and_res;
            `ALUK_ADD: begin
                res_c = add_res;
                cf_c  = add_cf;
                of_c  = add_of;
                af_c  = add_af;
            end
            `ALUK_MOVB: res_c = op2;
            `ALUK_MOVA: res_c = op1;
            `ALUK_NOT:  res_c = not_res;
            `ALUK_OR:   res_c = or_res;
            `ALUK_PADDW, `ALUK_PADDD, `ALUK_PACKSSWB, `ALUK_PUNPCKHBW: res_c = mmx_res;
            `ALUK_SAR: begin
                res_c = sar_res;
                cf_c  = sar_cf;
                of_c  = sar_of;
            end
            `ALUK_SAL: begin
                res_c = sal_res;
                cf_c  = sal_cf;
                of_c  = sal_of;
            end
            default: ;
        endcase
    end

    // common flags straight off the result
    assign zf_c = ~(|res_c);
    assign sf_c = size_sign(res_c, size);
    assign pf_c = byte_parity(res_c[7:0]);

    // zero-count shift leaves the flags untouched
    assign cc_inval_c = ((aluk == `ALUK_SAL) || (aluk == `ALUK_SAR)) && count_zero;

    ////////////////////////////////////////////////////////////
    // output stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            cc_inval  <= 1'b0;
            alu_out   <= '0;
            cf_out    <= 1'b0;
            pf_out    <= 1'b0;
            af_out    <= 1'b0;
            zf_out    <= 1'b0;
            sf_out    <= 1'b0;
            of_out    <= 1'b0;
        end else begin
            out_valid <= in_valid;
            // only meaningful alongside a valid result
            cc_inval  <= in_valid & cc_inval_c;
            if (in_valid) begin
                alu_out <= res_c;
                cf_out  <= cf_c;
                pf_out  <= pf_c;
                af_out  <= af_c;
                zf_out  <= zf_c;
                sf_out  <= sf_c;
                of_out  <= of_c;
            end
        end
    end

endmodule

/* hw/mmx_lane_merge.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module mmx_lane_merge (
    input  logic [4:0]                             aluk,
    input  logic [`ALU_DATA_W-1:0]                 op1,
    input  logic [`ALU_DATA_W-1:0]                 op2,
    input  logic [`MMX_LANES-1:0][`MMX_LANE_W-1:0] lane_sum,
    input  logic [`MMX_LANES-1:0][`MMX_LANE_W-1:0] lane_packed,
    output logic [`ALU_DATA_W-1:0]                 mmx_res
);
    import mmx_pkg::*;

    mmx_word_u a_u;
    mmx_word_u b_u;
    mmx_word_u res_u;

    assign a_u = op1;
    assign b_u = op2;

    always_comb begin
        res_u = '0;
        case (aluk)
            `ALUK_PADDW, `ALUK_PADDD: res_u.w = lane_sum;
            `ALUK_PACKSSWB:           res_u.w = lane_packed;
            // high half bytes, op1 on even slots and op2 on odd
            `ALUK_PUNPCKHBW: begin
                for (int k = 0; k < 4; k++) begin
                    res_u.b[2*k]   = a_u.b[4+k];
                    res_u.b[2*k+1] = b_u.b[4+k];
                end
            end
            default: ;
        endcase
    end

    assign mmx_res = res_u;

endmodule

/* hw/mmx_lane.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module mmx_lane (
    input  logic [`MMX_LANE_W-1:0] a,
    input  logic [`MMX_LANE_W-1:0] b,
    input  logic                   carry_in,
    output logic [`MMX_LANE_W-1:0] sum,
    output logic                   carry_out,
    output logic [`MMX_LANE_W-1:0] packed_bytes
);
    import mmx_pkg::*;

    // lane add, carry_out feeds the next lane for dword adds
    assign {carry_out, sum} = {1'b0, a} + {1'b0, b} + {{`MMX_LANE_W{1'b0}}, carry_in};

    // word pair down to a byte pair, a in the low byte
    assign packed_bytes = {sat_word_to_byte(b), sat_word_to_byte(a)};

endmodule

/* hw/mmx_lane_feed.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module mmx_lane_feed (
    input  logic [4:0]                           aluk,
    input  logic [`ALU_DATA_W-1:0]               op1,
    input  logic [`ALU_DATA_W-1:0]               op2,
    output logic [`MMX_LANES-1:0][`MMX_LANE_W-1:0] lane_a,
    output logic [`MMX_LANES-1:0][`MMX_LANE_W-1:0] lane_b,
    output logic [`MMX_LANES-1:0]                carry_link
);
    import mmx_pkg::*;

    mmx_word_u              a_u;
    mmx_word_u              b_u;
    logic [`MMX_LANES-1:1]  link_hi;

    assign a_u = op1;
    assign b_u = op2;

    always_comb begin
        // word i of each operand into lane i
        lane_a  = a_u.w;
        lane_b  = b_u.w;
        link_hi = '0;
        case (aluk)
            // lanes 1 and 3 take the carry of the lane below
            `ALUK_PADDD: link_hi = 3'b101;
            `ALUK_PACKSSWB: begin
                for (int j = 0; j < `MMX_LANES/2; j++) begin
                    {lane_b[j], lane_a[j]}                         = a_u.d[j];
                    {lane_b[j+`MMX_LANES/2], lane_a[j+`MMX_LANES/2]} = b_u.d[j];
                end
            end
            default: ;
        endcase
    end

    // lane 0 never chains
    assign carry_link = {link_hi, 1'b0};

endmodule

/* hw/shift_unit.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module shift_unit (
    input  logic [`ALU_DATA_W-1:0] op1,
    input  logic [`ALU_DATA_W-1:0] op2,
    input  logic                   of_in,
    output logic [`ALU_DATA_W-1:0] sal_res,
    output logic [`ALU_DATA_W-1:0] sar_res,
    output logic                   sal_cf,
    output logic                   sar_cf,
    output logic                   sal_of,
    output logic                   sar_of,
    output logic                   count_zero
);
    import flag_pkg::*;

    logic [4:0]               count;
    logic                     over;
    logic                     msb;
    logic [`ALU_SCALAR_W:0]   sal_ext;
    logic [`ALU_SCALAR_W:0]   sar_ext;
    logic [`ALU_SCALAR_W-1:0] sal_lo;
    logic [`ALU_SCALAR_W-1:0] sar_lo;

    assign count = op2[4:0];
    // any of bits 7:5 means the count runs past the dword
    assign over  = |op2[7:5];
    assign msb   = op1[`ALU_SCALAR_W-1];

    ////////////////////////////////////////////////////////////
    // extra bit on the far side catches the last bit shifted out
    assign sal_ext = {1'b0, op1[`ALU_SCALAR_W-1:0]} << count;
    assign sar_ext = $signed({op1[`ALU_SCALAR_W-1:0], 1'b0}) >>> count;

    assign sal_lo = over ? '0 : sal_ext[`ALU_SCALAR_W-1:0];
    assign sar_lo = over ? {`ALU_SCALAR_W{msb}} : sar_ext[`ALU_SCALAR_W:1];

    assign sal_res = {{(`ALU_DATA_W-`ALU_SCALAR_W){1'b0}}, sal_lo};
    assign sar_res = {{(`ALU_DATA_W-`ALU_SCALAR_W){1'b0}}, sar_lo};

    ////////////////////////////////////////////////////////////
    // flags
    assign sal_cf = over ? msb : sal_ext[`ALU_SCALAR_W];
    assign sar_cf = over ? msb : sar_ext[0];

    // of only defined for a single-bit shift, else it passes through
    assign sal_of = (count == 5'd1) ? (size_sign(sal_res, 2'd2) ^ sal_cf) : of_in;
    assign sar_of = (count == 5'd1) ? 1'b0 : of_in;

    assign count_zero = (count == 5'd0);

endmodule

/* hw/scalar_unit.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module scalar_unit (
    input  logic [4:0]             aluk,
    input  logic [`ALU_DATA_W-1:0] op1,
    input  logic [`ALU_DATA_W-1:0] op2,
    input  logic [1:0]             size,
    input  logic                   and_mask16,
    output logic [`ALU_DATA_W-1:0] and_res,
    output logic [`ALU_DATA_W-1:0] or_res,
    output logic [`ALU_DATA_W-1:0] not_res,
    output logic [`ALU_DATA_W-1:0] add_res,
    output logic                   add_cf,
    output logic                   add_of,
    output logic                   add_af
);
    import flag_pkg::*;

    logic [`ALU_DATA_W-1:0]   and_mask;
    logic                     add_en;
    logic [`ALU_SCALAR_W-1:0] add_a;
    logic [`ALU_SCALAR_W-1:0] add_b;
    logic [`ALU_SCALAR_W-1:0] add_sum;
    logic [`ALU_DATA_W-1:0]   a_ext;
    logic [`ALU_DATA_W-1:0]   b_ext;
    logic [1:0]               of_size;
    logic                     sign_a;
    logic                     sign_b;
    logic                     sign_s;

    // logic ops, mask form keeps only the low word of op1
    assign and_mask = and_mask16 ? {{(`ALU_DATA_W-16){1'b0}}, 16'hffff} : op2;
    assign and_res  = op1 & and_mask;
    assign or_res   = op1 | op2;
    assign not_res  = ~op1;

    // adder inputs held at zero outside ADD so the carry chain stays quiet
    assign add_en = (aluk == `ALUK_ADD);
    assign add_a  = add_en ? op1[`ALU_SCALAR_W-1:0] : '0;
    assign add_b  = add_en ? op2[`ALU_SCALAR_W-1:0] : '0;

    assign {add_cf, add_sum} = {1'b0, add_a} + {1'b0, add_b};
    assign add_res = {{(`ALU_DATA_W-`ALU_SCALAR_W){1'b0}}, add_sum};

    // nibble carry, bit 4 of the sum without the operand bits
    assign add_af = add_a[4] ^ add_b[4] ^ add_sum[4];

    // qword size still overflows at bit 31, the adder is only 32 wide
    assign of_size = (size == 2'd3) ? 2'd2 : size;

    assign a_ext = {{(`ALU_DATA_W-`ALU_SCALAR_W){1'b0}}, add_a};
    assign b_ext = {{(`ALU_DATA_W-`ALU_SCALAR_W){1'b0}}, add_b};

    assign sign_a = size_sign(a_ext, of_size);
    assign sign_b = size_sign(b_ext, of_size);
    assign sign_s = size_sign(add_res, of_size);

    // like signs in, other sign out
    assign add_of = (sign_a == sign_b) && (sign_s != sign_a);

endmodule

/* hw/flag_pkg.sv */
`include "alu_config.svh"

package flag_pkg;

    // x86 pf is set for an even number of ones in the low byte
    function automatic logic byte_parity(input logic [7:0] v);
        return ~(^v);
    endfunction

    // msb of the operand size, 0 byte .. 3 qword
    function automatic logic size_sign(input logic [`ALU_DATA_W-1:0] v, input logic [1:0] size);
        case (size)
            2'd0: return v[7];
            2'd1: return v[15];
            2'd2: return v[31];
            default: return v[`ALU_DATA_W-1];
        endcase
    endfunction

endpackage

/* hw/mmx_pkg.sv */
`include "alu_config.svh"

package mmx_pkg;

    // one mmx register seen as bytes, words or dwords
    typedef union packed {
        logic [`ALU_DATA_W/8-1:0][7:0]               b;
        logic [`MMX_LANES-1:0][`MMX_LANE_W-1:0]      w;
        logic [`ALU_DATA_W/32-1:0][31:0]             d;
    } mmx_word_u;

    // signed clamp of a word into -128..127
    function automatic logic [7:0] sat_word_to_byte(input logic [15:0] w);
        if (!w[15] && (|w[14:7]))
            return 8'h7f;
        else if (w[15] && !(&w[14:7]))
            return 8'h80;
        else
            return w[7:0];
    endfunction

endpackage

/* hw/alu_config.svh */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// operand and result width
`define ALU_DATA_W      64

// ADD and the shifts only look at the low dword
`define ALU_SCALAR_W    32

// simd split of the 64-bit word
`define MMX_LANES       4
`define MMX_LANE_W      16

// aluk opcode codes, same numbering as the execute decode
`define ALUK_AND        5'd0
`define ALUK_ADD        5'd1
`define ALUK_MOVB       5'd3
`define ALUK_MOVA       5'd4
`define ALUK_NOT        5'd9
`define ALUK_OR         5'd10

// mmx group
`define ALUK_PADDW      5'd11
`define ALUK_PADDD      5'd12
`define ALUK_PACKSSWB   5'd13
`define ALUK_PUNPCKHBW  5'd15

// shifts
`define ALUK_SAR        5'd17
`define ALUK_SAL        5'd18

`endif
